// ==== common/blur_pkg.sv ====
package blur_pkg;

    // Sample and result widths
    localparam int DATA_WIDTH   = 12;
    localparam int ACC_WIDTH    = 16;   // 16 x 4095 = 65520 still fits

    // Window depth, largest kernel
    localparam int MAX_TAPS     = 7;

    // Kernel weight, peak value 4 at the 7-tap centre
    localparam int WEIGHT_WIDTH = 3;

    // Fill count and tap count share one width
    localparam int FILL_WIDTH   = 3;

    // Size select code from the host
    localparam int SIZE_WIDTH   = 3;

    // One input sample
    typedef logic [DATA_WIDTH-1:0]   sample_t;

    // Full-width weighted sum, never normalized
    typedef logic [ACC_WIDTH-1:0]    acc_t;

    // One triangular weight
    typedef logic [WEIGHT_WIDTH-1:0] weight_t;

    // Codes 0..3 pick 1/3/5/7 taps, 4..7 fall back to 1 tap
    typedef logic [SIZE_WIDTH-1:0]   size_sel_t;

    // Samples held in the window, or active taps
    typedef logic [FILL_WIDTH-1:0]   fill_t;

endpackage

// ==== design/kernel_gen/blur_kernel_gen.sv ====
`timescale 1ns/10ps

module blur_kernel_gen (
    input  logic                 clk,
    input  logic                 rst,
    input  blur_pkg::size_sel_t  size_sel,
    input  logic                 size_load,
    output blur_pkg::fill_t      tap_count,
    output blur_pkg::weight_t    weights [0:blur_pkg::MAX_TAPS-1]
);

    import blur_pkg::*;

    size_sel_t size_q;  // Held kernel code

    // Kernel code only moves on a load strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            size_q <= '0;  // One tap out of reset
        end else if (size_load) begin
            size_q <= size_sel;
        end
    end

    // Code to odd tap count
    always_comb begin
        case (size_q)
            SIZE_WIDTH'(0): tap_count = FILL_WIDTH'(1);
            SIZE_WIDTH'(1): tap_count = FILL_WIDTH'(3);
            SIZE_WIDTH'(2): tap_count = FILL_WIDTH'(5);
            SIZE_WIDTH'(3): tap_count = FILL_WIDTH'(7);
            default:        tap_count = FILL_WIDTH'(1);  // Codes 4..7 fall back to one tap
        endcase
    end

    // Triangular row packed from position 0
    // Weight i+1 up to the peak and n-i after it
    always_comb begin
        for (int i = 0; i < MAX_TAPS; i++) begin
            if (i >= int'(tap_count)) begin
                weights[i] = '0;  // Unused tap
            end else if (i < int'(tap_count) - i) begin
                weights[i] = weight_t'(i + 1);
            end else begin
                weights[i] = weight_t'(int'(tap_count) - i);
            end
        end
    end

    // Only odd kernels from 1 to 7
    a_tap_count_odd: assert property (
        @(posedge clk) disable iff (rst)
        tap_count inside {FILL_WIDTH'(1), FILL_WIDTH'(3), FILL_WIDTH'(5), FILL_WIDTH'(7)}
    ) else $error("tap_count %0d is not a legal kernel size", tap_count);

endmodule

// ==== design/sample_window/sample_window.sv ====
`timescale 1ns/10ps

module sample_window (
    input  logic               clk,
    input  logic               rst,
    input  blur_pkg::sample_t  sample_in,
    input  logic               sample_valid,
    output blur_pkg::sample_t  taps [0:blur_pkg::MAX_TAPS-1],  // 0 is newest
    output blur_pkg::fill_t    fill,
    output logic               shifted       // Window moved last edge
);

    import blur_pkg::*;

    // Shift register that advances only on a strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MAX_TAPS; i++) begin
                taps[i] <= '0;  // Window starts empty
            end
        end else if (sample_valid) begin
            for (int i = MAX_TAPS - 1; i > 0; i--) begin
                taps[i] <= taps[i-1];  // Oldest drops off the end
            end
            taps[0] <= sample_in;
        end
    end

    // Saturating count of real samples
    always_ff @(posedge clk) begin
        if (rst) begin
            fill <= '0;
        end else if (sample_valid && (fill < FILL_WIDTH'(MAX_TAPS))) begin
            fill <= fill + FILL_WIDTH'(1);
        end
    end

    // One pulse per accepted sample
    always_ff @(posedge clk) begin
        if (rst) begin
            shifted <= 1'b0;
        end else begin
            shifted <= sample_valid;
        end
    end

    a_fill_max: assert property (
        @(posedge clk) disable iff (rst)
        fill <= FILL_WIDTH'(MAX_TAPS)
    ) else $error("fill %0d above window depth", fill);

endmodule

// ==== design/blur_mac/blur_mac.sv ====
`timescale 1ns/10ps

module blur_mac (
    input  logic               clk,
    input  logic               rst,
    input  blur_pkg::sample_t  taps [0:blur_pkg::MAX_TAPS-1],
    input  blur_pkg::fill_t    fill,
    input  logic               shifted,
    input  blur_pkg::fill_t    tap_count,
    input  blur_pkg::weight_t  weights [0:blur_pkg::MAX_TAPS-1],
    output blur_pkg::acc_t     blur_out,
    output logic               out_valid
);

    import blur_pkg::*;

    acc_t sum;           // Combinational weighted sum
    logic window_ready;  // Enough samples for this kernel

    // Sum of all seven products since unused weights are zero
    // Worst case 16 x 4095 = 65520 fits in 16 bits
    always_comb begin
        sum = '0;
        for (int i = 0; i < MAX_TAPS; i++) begin
            sum = sum + ACC_WIDTH'(taps[i]) * ACC_WIDTH'(weights[i]);
        end
    end

    assign window_ready = (fill >= tap_count);

    // Result register loads on each shift
    always_ff @(posedge clk) begin
        if (shifted) begin
            blur_out <= sum;
        end
    end

    // Strobe only once the window is deep enough
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= shifted && window_ready;
        end
    end

    // Output strobe traces back to a window shift
    a_valid_after_shift: assert property (
        @(posedge clk) disable iff (rst)
        out_valid |-> $past(shifted)
    ) else $error("out_valid without a shift one cycle earlier");

endmodule

// ==== design/blur_filter_top.sv ====
`timescale 1ns/10ps

module blur_filter_top (
    input  logic                 clk,
    input  logic                 rst,
    input  blur_pkg::sample_t    sample_in,
    input  logic                 sample_valid,  // One sample per high cycle
    input  blur_pkg::size_sel_t  size_sel,
    input  logic                 size_load,     // Kernel update strobe
    output blur_pkg::acc_t       blur_out,
    output logic                 out_valid      // Two cycles after sample_valid
);

    import blur_pkg::*;

    // Kernel to MAC
    fill_t   tap_count;
    weight_t weights [0:MAX_TAPS-1];

    // Window to MAC
    sample_t taps [0:MAX_TAPS-1];
    fill_t   fill;
    logic    shifted;

    // Weight producer
    blur_kernel_gen i_kernel_gen (
        .clk       (clk),
        .rst       (rst),
        .size_sel  (size_sel),
        .size_load (size_load),
        .tap_count (tap_count),
        .weights   (weights)
    );

    // Sample buffer, first pipeline stage
    sample_window i_sample_window (
        .clk          (clk),
        .rst          (rst),
        .sample_in    (sample_in),
        .sample_valid (sample_valid),
        .taps         (taps),
        .fill         (fill),
        .shifted      (shifted)
    );

    // Weighted sum, second pipeline stage
    blur_mac i_blur_mac (
        .clk       (clk),
        .rst       (rst),
        .taps      (taps),
        .fill      (fill),
        .shifted   (shifted),
        .tap_count (tap_count),
        .weights   (weights),
        .blur_out  (blur_out),
        .out_valid (out_valid)
    );

endmodule

// ==== dv/blur_filter_tb.sv ====
`timescale 1ns/10ps

module blur_filter_tb;

    import blur_pkg::*;

    localparam int CLK_HALF    = 10;    // 20 ns period
    localparam int DRIVE_DELAY = 2;     // Inputs move just after the edge
    localparam int CYCLE_LIMIT = 1500;  // Roughly 600 test cycles with margin

    logic      clk;
    logic      rst;
    sample_t   sample_in;
    logic      sample_valid;
    size_sel_t size_sel;
    logic      size_load;
    acc_t      blur_out;
    logic      out_valid;

    // Reference model
    sample_t     hist [0:MAX_TAPS-1];  // 0 is newest
    int          m_fill;               // Samples held up to 7
    int          m_taps;               // Active kernel size
    logic        m_shifted;            // Strobe taken on the last edge

    logic [31:0] seed;
    int          cycle_count = 0;
    int          out_seen;             // out_valid pulses since reset
    acc_t        last_out;

    blur_filter_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .sample_in    (sample_in),
        .sample_valid (sample_valid),
        .size_sel     (size_sel),
        .size_load    (size_load),
        .blur_out     (blur_out),
        .out_valid    (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    // Run guard
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("tests failed");
            $fatal(1, "simulation stopped on timeout");
        end
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic sample_t rand_sample();
        logic [31:0] r;
        r = lcg_next();
        return sample_t'(r[27:16]);  // Upper bits spread better
    endfunction

    // Size code to tap count
    function automatic int kernel_taps(input size_sel_t code);
        case (code)
            3'd1:    return 3;
            3'd2:    return 5;
            3'd3:    return 7;
            default: return 1;  // Code 0 and the 4..7 fallback
        endcase
    endfunction

    // Triangular sum over the model history
    function automatic acc_t tri_sum(input int n);
        int s;
        case (n)
            3: s = hist[0] + 2 * hist[1] + hist[2];
            5: s = hist[0] + 2 * hist[1] + 3 * hist[2] + 2 * hist[3] + hist[4];
            7: s = hist[0] + 2 * hist[1] + 3 * hist[2] + 4 * hist[3]
                   + 3 * hist[4] + 2 * hist[5] + hist[6];
            default: s = hist[0];
        endcase
        return acc_t'(s);
    endfunction

    task automatic stop_on_error();
        $display("tests failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("FAIL t=%0t %s expected %0d got %0d", $time, name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_strobe(input logic exp_valid);
        assert (out_valid === exp_valid) else begin
            if (exp_valid) begin
                $display("The out_valid strobe did not arrive when expected at %0t", $time);
            end else begin
                $display("An unexpected out_valid strobe arrived at %0t", $time);
            end
            stop_on_error();
        end
    endtask

    task automatic model_reset();
        for (int i = 0; i < MAX_TAPS; i++) begin
            hist[i] = '0;
        end
        m_fill    = 0;
        m_taps    = 1;  // One tap after reset
        m_shifted = 1'b0;
        out_seen  = 0;
    endtask

    // Starts and ends at drive time
    task automatic apply_reset();
        rst          = 1'b1;
        sample_valid = 1'b0;
        size_load    = 1'b0;
        repeat (2) @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b0;
        model_reset();
        check_strobe(1'b0);
    endtask

    // One clock of drive, model step and check
    task automatic drive_cycle(input logic v, input sample_t s, input logic ld,
                               input size_sel_t code);
        logic exp_valid;
        acc_t exp_out;
        sample_valid = v;
        sample_in    = v ? s : sample_t'(0);
        size_load    = ld;
        size_sel     = code;
        @(posedge clk);
        #(DRIVE_DELAY);
        // Result on this edge is the previous shift under the old kernel
        exp_valid = m_shifted && (m_fill >= m_taps);
        exp_out   = tri_sum(m_taps);
        m_shifted = v;
        if (v) begin
            for (int i = MAX_TAPS - 1; i > 0; i--) begin
                hist[i] = hist[i-1];
            end
            hist[0] = s;
            if (m_fill < MAX_TAPS) begin
                m_fill++;
            end
        end
        if (ld) begin
            m_taps = kernel_taps(code);  // Applies from the next result on
        end
        check_strobe(exp_valid);
        if (exp_valid) begin
            check_value("blur_out", exp_out, blur_out);
        end
        if (out_valid === 1'b1) begin
            out_seen++;
            last_out = blur_out;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_cycle(1'b0, '0, 1'b0, '0);
    endtask

    task automatic strobe_samples(input int n);
        repeat (n) drive_cycle(1'b1, rand_sample(), 1'b0, '0);
    endtask

    task automatic load_size(input int code);
        drive_cycle(1'b0, '0, 1'b1, size_sel_t'(code));
    endtask

    // Default one tap returns each sample as is
    task automatic reset_and_passthrough();
        apply_reset();
        idle_cycles(2);
        strobe_samples(8);
        idle_cycles(3);
        check_value("out_valid count", 8, out_seen);
    endtask

    task automatic three_tap_kernel();
        apply_reset();
        load_size(1);
        strobe_samples(2);  // Window too shallow yet
        idle_cycles(3);
        check_value("out_valid count", 0, out_seen);
        strobe_samples(10);
        idle_cycles(3);
        check_value("out_valid count", 10, out_seen);
    endtask

    task automatic five_and_seven_taps();
        apply_reset();
        load_size(2);
        strobe_samples(4);
        idle_cycles(3);
        check_value("out_valid count", 0, out_seen);
        strobe_samples(30);
        idle_cycles(3);
        check_value("out_valid count", 30, out_seen);

        apply_reset();
        load_size(3);
        strobe_samples(6);
        idle_cycles(3);
        check_value("out_valid count", 0, out_seen);
        strobe_samples(30);
        idle_cycles(3);
        check_value("out_valid count", 30, out_seen);

        // Full scale at 7 taps gives 16 x 4095
        apply_reset();
        load_size(3);
        repeat (9) drive_cycle(1'b1, sample_t'(12'hfff), 1'b0, '0);
        idle_cycles(3);
        check_value("out_valid count", 3, out_seen);
        check_value("blur_out", 65520, last_out);
    endtask

    // Kernel swaps without a window flush
    task automatic size_change_midstream();
        apply_reset();
        load_size(3);
        strobe_samples(10);
        drive_cycle(1'b1, rand_sample(), 1'b1, size_sel_t'(1));  // Load with a strobe
        strobe_samples(8);
        load_size(3);
        strobe_samples(8);
        for (int code = 4; code < 8; code++) begin
            load_size(code);  // Fallback codes
            strobe_samples(4);
        end
        idle_cycles(3);
    endtask

    task automatic strobe_patterns();
        logic [31:0] r;
        apply_reset();
        load_size(2);
        strobe_samples(20);  // Back to back
        for (int i = 0; i < 30; i++) begin
            r = lcg_next();
            idle_cycles(int'(r[31:29]));  // Gap of 0..7 cycles
            strobe_samples(1);
        end
        idle_cycles(10);  // Long idle with no strobe
    endtask

    initial begin
        rst          = 1'b1;
        sample_in    = '0;
        sample_valid = 1'b0;
        size_sel     = '0;
        size_load    = 1'b0;
        seed         = 32'h512;
        last_out     = '0;
        model_reset();

        reset_and_passthrough();
        three_tap_kernel();
        five_and_seven_taps();
        size_change_midstream();
        strobe_patterns();

        $display("all tests passed");
        $finish;
    end

endmodule

// ==== blur_filter_top.f ====
common/blur_pkg.sv
design/kernel_gen/blur_kernel_gen.sv
design/sample_window/sample_window.sv
design/blur_mac/blur_mac.sv
design/blur_filter_top.sv
dv/blur_filter_tb.sv

// ==== Bender.yml ====
package:
  name: blur_filter

sources:
  # Shared package first
  - common/blur_pkg.sv
  # RTL blocks, then the top level
  - design/kernel_gen/blur_kernel_gen.sv
  - design/sample_window/sample_window.sv
  - design/blur_mac/blur_mac.sv
  - design/blur_filter_top.sv
  # Testbench
  - target: simulation
    files:
      - dv/blur_filter_tb.sv
